/* include/ahb_params.svh */
/*
 * bus widths, wait-state timeout and 1 KB boundary bit for the AHB-Lite master
 */
`ifndef AHB_PARAMS_SVH
`define AHB_PARAMS_SVH

// bus widths
`define AHB_ADDR_WIDTH 32
`define AHB_DATA_WIDTH 32

`define AHB_WAIT_TIMEOUT 6  // wait cycles allowed in one data phase

// lowest address bit of a 1 KB region
`define AHB_KB_BIT 10

`endif

/* source/ahb_bus_pkg.sv */
/*
 * AHB protocol types: transfer type, burst type and transfer size
 */
package ahb_bus_pkg;

    // BUSY is never driven by this master
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        SINGLE = 3'd0,
        INCR   = 3'd1,  // undefined length
        WRAP4  = 3'd2,
        INCR4  = 3'd3,
        WRAP8  = 3'd4,
        INCR8  = 3'd5,
        WRAP16 = 3'd6,
        INCR16 = 3'd7
    } hburst_t;

    // bytes per beat is 1 << size
    typedef enum logic [2:0] {
        BYTE     = 3'd0,
        HALF     = 3'd1,
        WORD     = 3'd2,
        DWORD    = 3'd3,
        LINE4    = 3'd4,  // 128 bits
        LINE8    = 3'd5,  // 256 bits
        SIZE512  = 3'd6,
        SIZE1024 = 3'd7
    } hsize_t;

endpackage

/* source/ahb_master_pkg.sv */
/*
 * master FSM state encoding and remaining beat counter type
 */
`include "ahb_params.svh"

package ahb_master_pkg;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_NONSEQ = 2'd1,  // first beat of a burst
        ST_SEQ    = 2'd2,
        ST_ERROR  = 2'd3   // one idle cycle after an abort
    } master_state_t;

    // beats left after the current address phase
    typedef logic [3:0] beat_cnt_t;

endpackage

/* source/ahb_cmd_check.sv */
/*
 * client command check: size against data bus, 1 KB boundary, beat count
 */
`timescale 1ns/1ps
`include "ahb_params.svh"

module ahb_cmd_check import ahb_bus_pkg::*, ahb_master_pkg::*; (
    input  logic [`AHB_ADDR_WIDTH-1:0] cmd_addr,
    input  hburst_t                    cmd_burst,
    input  hsize_t                     cmd_size,
    output logic                       cmd_ok,
    output beat_cnt_t                  cmd_beats
);
    localparam int AW = `AHB_ADDR_WIDTH;

    logic          burst_ok;
    logic [10:0]   size_bits;
    logic          size_ok;
    logic [AW-1:0] size_mask;
    logic          aligned;
    logic [AW-1:0] span;
    logic [AW-1:0] last_addr;
    logic          crosses_kb;

    always_comb begin
        burst_ok = 1'b1;
        case (cmd_burst)
            WRAP4, INCR4:   cmd_beats = 4'd3;
            WRAP8, INCR8:   cmd_beats = 4'd7;
            WRAP16, INCR16: cmd_beats = 4'd15;
            INCR: begin
                cmd_beats = 4'd0;
                burst_ok  = 1'b0;  // undefined length not supported
            end
            default:        cmd_beats = 4'd0;
        endcase
    end

    assign size_bits = 11'd8 << cmd_size;
    assign size_ok   = (size_bits <= 11'(`AHB_DATA_WIDTH));

    assign size_mask = (AW'(1) << cmd_size) - AW'(1);
    assign aligned   = ((cmd_addr & size_mask) == '0);

    // last byte touched if the burst simply incremented
    assign span       = (AW'(cmd_beats) + AW'(1)) << cmd_size;
    assign last_addr  = cmd_addr + span - AW'(1);
    assign crosses_kb = (last_addr[AW-1:`AHB_KB_BIT] != cmd_addr[AW-1:`AHB_KB_BIT]);

    assign cmd_ok = burst_ok && size_ok && (aligned || !crosses_kb);

endmodule

/* source/ahb_addr_gen.sv */
/*
 * beat address register with incrementing and wrapping next address,
 * holds burst type and size of the running command
 */
`timescale 1ns/1ps
`include "ahb_params.svh"

module ahb_addr_gen import ahb_bus_pkg::*; (
    input  logic                       ahb_clk_in,
    input  logic                       ahb_rstn_in,
    input  logic                       load,
    input  logic                       advance,
    input  logic [`AHB_ADDR_WIDTH-1:0] cmd_addr,
    input  hburst_t                    cmd_burst,
    input  hsize_t                     cmd_size,
    output logic [`AHB_ADDR_WIDTH-1:0] haddr,
    output hburst_t                    hburst,
    output hsize_t                     hsize
);
    localparam int AW = `AHB_ADDR_WIDTH;

    logic [AW-1:0] size_bytes;
    logic [AW-1:0] incr_addr;
    logic [3:0]    wrap_shift;
    logic [AW-1:0] wrap_mask;
    logic [AW-1:0] next_addr;

    assign size_bytes = AW'(1) << hsize;
    assign incr_addr  = haddr + size_bytes;

    // log2 of beats in a wrapping burst, 0 when not wrapping
    always_comb begin
        case (hburst)
            WRAP4:   wrap_shift = 4'd2;
            WRAP8:   wrap_shift = 4'd3;
            WRAP16:  wrap_shift = 4'd4;
            default: wrap_shift = 4'd0;
        endcase
    end

    // wrap block is beats * size bytes
    assign wrap_mask = (AW'(1) << ({1'b0, hsize} + wrap_shift)) - AW'(1);

    always_comb begin
        if (wrap_shift != 4'd0) begin
            next_addr = (haddr & ~wrap_mask) | (incr_addr & wrap_mask);  // upper bits kept
        end else begin
            next_addr = incr_addr;
        end
    end

    always_ff @(posedge ahb_clk_in) begin
        if (!ahb_rstn_in) begin
            haddr  <= '0;
            hburst <= SINGLE;
            hsize  <= BYTE;
        end else if (load) begin
            haddr  <= cmd_addr;
            hburst <= cmd_burst;
            hsize  <= cmd_size;
        end else if (advance) begin
            haddr  <= next_addr;
        end
    end

endmodule

/* source/ahb_master_fsm.sv */
/*
 * transfer FSM: command acceptance, htrans generation, beat counting,
 * abort handling through an error state
 */
`timescale 1ns/1ps

module ahb_master_fsm import ahb_bus_pkg::*, ahb_master_pkg::*; (
    input  logic      ahb_clk_in,
    input  logic      ahb_rstn_in,
    input  logic      cmd_valid,
    input  logic      cmd_write,
    input  logic      cmd_ok,
    input  beat_cnt_t cmd_beats,
    input  logic      hready,
    input  logic      abort,
    output htrans_t   htrans,
    output logic      hwrite,
    output logic      load,
    output logic      advance,
    output logic      addr_taken,
    output logic      cmd_accept,
    output logic      cmd_error,
    output logic      last_beat
);
    master_state_t state;
    master_state_t state_nxt;
    beat_cnt_t     beat_cnt;
    logic          start;
    logic          addr_phase;

    // cmd_accept high means the client has not yet dropped cmd_valid
    assign start = (state == ST_IDLE) && cmd_valid && !cmd_accept && !abort;
    assign load  = start && cmd_ok;

    assign addr_phase = (state == ST_NONSEQ) || (state == ST_SEQ);
    assign addr_taken = addr_phase && hready;
    assign last_beat  = (beat_cnt == 4'd0);
    assign advance    = addr_taken && !last_beat;

    always_comb begin
        case (state)
            ST_NONSEQ: htrans = NONSEQ;
            ST_SEQ:    htrans = SEQ;
            default:   htrans = IDLE;
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (abort) begin
                    state_nxt = ST_ERROR;  // last beat failed
                end else if (load) begin
                    state_nxt = ST_NONSEQ;
                end
            end
            ST_NONSEQ, ST_SEQ: begin
                if (abort) begin
                    state_nxt = ST_ERROR;
                end else if (addr_taken) begin
                    state_nxt = last_beat ? ST_IDLE : ST_SEQ;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge ahb_clk_in) begin
        if (!ahb_rstn_in) begin
            state      <= ST_IDLE;
            beat_cnt   <= 4'd0;
            hwrite     <= 1'b0;
            cmd_accept <= 1'b0;
            cmd_error  <= 1'b0;
        end else begin
            state      <= state_nxt;
            cmd_accept <= start;
            cmd_error  <= start && !cmd_ok;  // rejected, stays idle
            if (load) begin
                beat_cnt <= cmd_beats;
                hwrite   <= cmd_write;
            end else if (advance) begin
                beat_cnt <= beat_cnt - 4'd1;
            end
        end
    end

endmodule

/* source/ahb_data_phase.sv */
/*
 * data phase tracking: write data launch, read capture, error response and
 * wait-state timeout detection, beat and burst reporting
 */
`timescale 1ns/1ps
`include "ahb_params.svh"

module ahb_data_phase #(
    parameter int WAIT_TIMEOUT = `AHB_WAIT_TIMEOUT
) (
    input  logic                       ahb_clk_in,
    input  logic                       ahb_rstn_in,
    input  logic                       addr_taken,
    input  logic                       last_beat,
    input  logic                       hwrite,
    input  logic [`AHB_DATA_WIDTH-1:0] wr_data,
    input  logic [`AHB_DATA_WIDTH-1:0] hrdata,
    input  logic                       hready,
    input  logic                       hresp,
    output logic [`AHB_DATA_WIDTH-1:0] hwdata,
    output logic                       wr_take,
    output logic [`AHB_DATA_WIDTH-1:0] rd_data,
    output logic                       beat_done,
    output logic                       beat_error,
    output logic                       burst_done,
    output logic                       burst_error,
    output logic                       abort
);
    localparam int CNT_W = $clog2(WAIT_TIMEOUT + 1);

    logic             pending;     // a data phase is on the bus
    logic             pend_last;
    logic             pend_write;
    logic             pend_err;    // first error cycle seen
    logic [CNT_W-1:0] wait_cnt;
    logic             phase_end;
    logic             err_start;
    logic             timeout;

    assign phase_end = pending && hready;
    assign err_start = pending && !hready && hresp && !pend_err;
    assign timeout   = pending && !hready && (wait_cnt == CNT_W'(WAIT_TIMEOUT - 1));
    assign abort     = err_start || timeout;

    always_ff @(posedge ahb_clk_in) begin
        if (!ahb_rstn_in) begin
            pending     <= 1'b0;
            pend_last   <= 1'b0;
            pend_write  <= 1'b0;
            pend_err    <= 1'b0;
            wait_cnt    <= '0;
            wr_take     <= 1'b0;
            beat_done   <= 1'b0;
            beat_error  <= 1'b0;
            burst_done  <= 1'b0;
            burst_error <= 1'b0;
        end else begin
            wr_take     <= addr_taken && hwrite;
            beat_done   <= phase_end || timeout;
            beat_error  <= (phase_end && pend_err) || timeout;
            burst_done  <= (phase_end && (pend_last || pend_err)) || timeout;
            burst_error <= (phase_end && pend_err) || timeout;

            if (addr_taken) begin
                pending    <= 1'b1;  // may overlap the end of the previous beat
                pend_last  <= last_beat;
                pend_write <= hwrite;
                pend_err   <= 1'b0;
            end else if (phase_end || timeout) begin
                pending  <= 1'b0;
                pend_err <= 1'b0;
            end else if (err_start) begin
                pend_err <= 1'b1;
            end

            if (pending && !hready && !timeout) begin
                wait_cnt <= wait_cnt + CNT_W'(1);
            end else begin
                wait_cnt <= '0;
            end
        end
    end

    always_ff @(posedge ahb_clk_in) begin
        if (addr_taken && hwrite) begin
            hwdata <= wr_data;
        end
        if (phase_end && !pend_write) begin
            rd_data <= hrdata;
        end
    end

endmodule

/* source/ahb_master_top.sv */
/*
 * AHB-Lite master top: command check, address generator, FSM, data phase
 */
`timescale 1ns/1ps
`include "ahb_params.svh"

module ahb_master_top import ahb_bus_pkg::*, ahb_master_pkg::*; (
    input  logic                       ahb_clk_in,
    input  logic                       ahb_rstn_in,
    // client side
    input  logic                       cmd_valid,
    input  logic [`AHB_ADDR_WIDTH-1:0] cmd_addr,
    input  hburst_t                    cmd_burst,
    input  hsize_t                     cmd_size,
    input  logic                       cmd_write,
    output logic                       cmd_accept,
    output logic                       cmd_error,
    input  logic [`AHB_DATA_WIDTH-1:0] wr_data,
    output logic                       wr_take,
    output logic [`AHB_DATA_WIDTH-1:0] rd_data,
    output logic                       beat_done,
    output logic                       beat_error,
    output logic                       burst_done,
    output logic                       burst_error,
    // bus side
    output logic [`AHB_ADDR_WIDTH-1:0] haddr,
    output htrans_t                    htrans,
    output hburst_t                    hburst,
    output hsize_t                     hsize,
    output logic                       hwrite,
    output logic [`AHB_DATA_WIDTH-1:0] hwdata,
    input  logic [`AHB_DATA_WIDTH-1:0] hrdata,
    input  logic                       hready,
    input  logic                       hresp
);
    logic      cmd_ok;
    beat_cnt_t cmd_beats;
    logic      load;
    logic      advance;
    logic      addr_taken;
    logic      last_beat;
    logic      abort;

    ahb_cmd_check u_cmd_check (
        .cmd_addr  (cmd_addr),
        .cmd_burst (cmd_burst),
        .cmd_size  (cmd_size),
        .cmd_ok    (cmd_ok),
        .cmd_beats (cmd_beats)
    );

    ahb_addr_gen u_addr_gen (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .load        (load),
        .advance     (advance),
        .cmd_addr    (cmd_addr),
        .cmd_burst   (cmd_burst),
        .cmd_size    (cmd_size),
        .haddr       (haddr),
        .hburst      (hburst),
        .hsize       (hsize)
    );

    ahb_master_fsm u_fsm (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .cmd_valid   (cmd_valid),
        .cmd_write   (cmd_write),
        .cmd_ok      (cmd_ok),
        .cmd_beats   (cmd_beats),
        .hready      (hready),
        .abort       (abort),
        .htrans      (htrans),
        .hwrite      (hwrite),
        .load        (load),
        .advance     (advance),
        .addr_taken  (addr_taken),
        .cmd_accept  (cmd_accept),
        .cmd_error   (cmd_error),
        .last_beat   (last_beat)
    );

    ahb_data_phase #(
        .WAIT_TIMEOUT (`AHB_WAIT_TIMEOUT)
    ) u_data_phase (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .addr_taken  (addr_taken),
        .last_beat   (last_beat),
        .hwrite      (hwrite),
        .wr_data     (wr_data),
        .hrdata      (hrdata),
        .hready      (hready),
        .hresp       (hresp),
        .hwdata      (hwdata),
        .wr_take     (wr_take),
        .rd_data     (rd_data),
        .beat_done   (beat_done),
        .beat_error  (beat_error),
        .burst_done  (burst_done),
        .burst_error (burst_error),
        .abort       (abort)
    );

endmodule

/* test/ahb_slave_model.sv */
/*
 * AHB-Lite memory slave for the testbench: random wait states,
 * a two-cycle ERROR response at one address and an endless stall at another
 */
`timescale 1ns/1ps
`include "ahb_params.svh"

module ahb_slave_model import ahb_bus_pkg::*; #(
    parameter logic [`AHB_ADDR_WIDTH-1:0] ERR_ADDR   = 32'h0000_0800,
    parameter logic [`AHB_ADDR_WIDTH-1:0] STALL_ADDR = 32'h0000_0C00
) (
    input  logic                       ahb_clk_in,
    input  logic                       ahb_rstn_in,
    input  logic [`AHB_ADDR_WIDTH-1:0] haddr,
    input  htrans_t                    htrans,
    input  logic                       hwrite,
    input  logic [`AHB_DATA_WIDTH-1:0] hwdata,
    output logic [`AHB_DATA_WIDTH-1:0] hrdata,
    output logic                       hready,
    output logic                       hresp
);
    localparam logic [1:0] MODE_OK    = 2'd0;
    localparam logic [1:0] MODE_ERR   = 2'd1;
    localparam logic [1:0] MODE_STALL = 2'd2;

    logic [`AHB_DATA_WIDTH-1:0] mem [0:4095];  // one word per byte address
    logic                       busy;          // data phase in progress
    logic [11:0]                d_addr;
    logic                       d_write;
    logic [1:0]                 mode;
    logic [1:0]                 cnt;           // wait cycles left
    int                         i;

    initial begin
        for (i = 0; i < 4096; i++) begin
            mem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0003);
        end
        hready = 1'b1;
        hresp  = 1'b0;
        hrdata = '0;
    end

    always @(posedge ahb_clk_in) begin
        if (!ahb_rstn_in) begin
            busy    <= 1'b0;
            d_addr  <= '0;
            d_write <= 1'b0;
            mode    <= MODE_OK;
            cnt     <= '0;
        end else if (hready) begin
            if (busy && d_write && mode == MODE_OK) begin
                mem[d_addr] <= hwdata;
            end
            busy    <= htrans[1];  // NONSEQ or SEQ
            d_addr  <= haddr[11:0];
            d_write <= hwrite;
            if (haddr == ERR_ADDR) begin
                mode <= MODE_ERR;
                cnt  <= 2'd1;
            end else if (haddr == STALL_ADDR) begin
                mode <= MODE_STALL;
            end else begin
                mode <= MODE_OK;
                cnt  <= 2'($urandom % 4);
            end
        end else if (mode == MODE_STALL) begin
            if (htrans == NONSEQ) begin
                busy <= 1'b0;  // a new transfer frees the slave
            end
        end else begin
            cnt <= cnt - 2'd1;
        end
    end

    // outputs change on the falling edge
    always @(negedge ahb_clk_in) begin
        if (!ahb_rstn_in) begin
            hready <= 1'b1;
            hresp  <= 1'b0;
        end else begin
            hready <= !busy || (mode != MODE_STALL && cnt == 2'd0);
            hresp  <= busy && (mode == MODE_ERR);
            hrdata <= mem[d_addr];
        end
    end

endmodule

/* test/tb_ahb_master.sv */
/*
 * testbench for the AHB-Lite master: clock, reset, command stimulus,
 * bus and client side checks against a reference memory
 */
`timescale 1ns/1ps
`include "ahb_params.svh"

module tb_ahb_master import ahb_bus_pkg::*;;
    logic        ahb_clk_in;
    logic        ahb_rstn_in;
    logic        cmd_valid;
    logic [31:0] cmd_addr;
    hburst_t     cmd_burst;
    hsize_t      cmd_size;
    logic        cmd_write;
    logic        cmd_accept;
    logic        cmd_error;
    logic [31:0] wr_data;
    logic        wr_take;
    logic [31:0] rd_data;
    logic        beat_done;
    logic        beat_error;
    logic        burst_done;
    logic        burst_error;
    logic [31:0] haddr;
    htrans_t     htrans;
    hburst_t     hburst;
    hsize_t      hsize;
    logic        hwrite;
    logic [31:0] hwdata;
    logic [31:0] hrdata;
    logic        hready;
    logic        hresp;

    logic [31:0] exp_addr [0:15];
    logic [31:0] wdata [0:16];
    logic [31:0] ref_mem [0:4095];  // words written so far
    int          n_beats;
    int          fail_beat;         // beat expected to end in error, -1 for none
    logic        cur_write;
    hburst_t     cur_burst;
    hsize_t      cur_size;
    int          beat_idx;
    int          done_cnt;
    int          wr_idx;
    int unsigned seed;
    int          i;
    hsize_t      sz;
    logic [31:0] start;

    ahb_master_top dut0 (.*);

    ahb_slave_model slave0 (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .haddr       (haddr),
        .htrans      (htrans),
        .hwrite      (hwrite),
        .hwdata      (hwdata),
        .hrdata      (hrdata),
        .hready      (hready),
        .hresp       (hresp)
    );

    initial begin
        ahb_clk_in = 1'b0;
        forever #20 ahb_clk_in = ~ahb_clk_in;
    end

    task automatic stop_run(input string reason);
        $display("TEST FAILED");
        $display("%s", reason);
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_run($sformatf("error %s: got %h, expected %h", name, got, exp));
    endtask

    function automatic int beats_of(input hburst_t b);
        case (b)
            WRAP4, INCR4:   return 4;
            WRAP8, INCR8:   return 8;
            WRAP16, INCR16: return 16;
            default:        return 1;
        endcase
    endfunction

    // present a command and hold it until accepted
    task automatic issue(input logic [31:0] addr, input hburst_t burst, input hsize_t size,
                         input logic write);
        int cycles;
        cmd_addr  = addr;
        cmd_burst = burst;
        cmd_size  = size;
        cmd_write = write;
        cmd_valid = 1'b1;
        cycles    = 0;
        while (!cmd_accept) begin
            @(negedge ahb_clk_in);
            cycles++;
            if (cycles > 10) stop_run("timeout waiting for cmd_accept");
        end
        cmd_valid = 1'b0;
    endtask

    task automatic run_cmd(input logic [31:0] addr, input hburst_t burst, input hsize_t size,
                           input logic write, input int fail_at, input int limit);
        logic [31:0] step;
        logic [31:0] block;
        logic [31:0] base;
        int          k;
        int          cycles;
        int          exp_done;
        n_beats = beats_of(burst);
        step    = 32'd1 << size;
        block   = n_beats * step;
        base    = addr - (addr % block);  // wrap block
        for (k = 0; k < n_beats; k++) begin
            if (burst == WRAP4 || burst == WRAP8 || burst == WRAP16) begin
                exp_addr[k] = base + ((addr - base + k * step) % block);
            end else begin
                exp_addr[k] = addr + k * step;
            end
            wdata[k] = $urandom;
        end
        exp_done  = (fail_at < 0) ? n_beats : fail_at + 1;
        fail_beat = fail_at;
        cur_write = write;
        cur_burst = burst;
        cur_size  = size;
        beat_idx  = 0;
        done_cnt  = 0;
        wr_idx    = 0;
        wr_data   = wdata[0];
        issue(addr, burst, size, write);
        assert (!cmd_error) else report_mismatch("cmd_error", cmd_error, 0);
        cycles = 0;
        while (!burst_done) begin
            if (wr_take) begin
                assert (hwdata == wdata[wr_idx])
                    else report_mismatch("hwdata", hwdata, wdata[wr_idx]);
                wr_idx++;
                wr_data = wdata[wr_idx];
            end
            @(negedge ahb_clk_in);
            cycles++;
            if (cycles > limit) stop_run("timeout waiting for burst_done");
        end
        assert (htrans == IDLE) else report_mismatch("htrans", htrans, IDLE);
        // last beat report is sampled at the coming rising edge
        @(negedge ahb_clk_in);
        assert (done_cnt == exp_done) else report_mismatch("beat_done count", done_cnt, exp_done);
        assert (wr_idx == (write ? beat_idx : 0))
            else report_mismatch("wr_take count", wr_idx, write ? beat_idx : 0);
    endtask

    task automatic reject_cmd(input logic [31:0] addr, input hburst_t burst, input hsize_t size);
        n_beats = 0;  // any address phase now is a failure
        issue(addr, burst, size, 1'b1);
        assert (cmd_error) else report_mismatch("cmd_error", cmd_error, 1);
        repeat (4) begin
            @(negedge ahb_clk_in);
            assert (htrans == IDLE) else report_mismatch("htrans", htrans, IDLE);
        end
    endtask

    // address phase and beat report checks
    always @(posedge ahb_clk_in) begin
        if (ahb_rstn_in) begin
            if (htrans[1] && hready) begin
                assert (beat_idx < n_beats && (fail_beat < 0 || beat_idx <= fail_beat))
                    else stop_run("address phase beyond the end of the burst");
                assert (haddr == exp_addr[beat_idx])
                    else report_mismatch("haddr", haddr, exp_addr[beat_idx]);
                assert (htrans == (beat_idx == 0 ? NONSEQ : SEQ))
                    else report_mismatch("htrans", htrans, beat_idx == 0 ? NONSEQ : SEQ);
                assert (hburst == cur_burst) else report_mismatch("hburst", hburst, cur_burst);
                assert (hsize == cur_size) else report_mismatch("hsize", hsize, cur_size);
                assert (hwrite == cur_write) else report_mismatch("hwrite", hwrite, cur_write);
                beat_idx++;
            end
            if (beat_done) begin
                assert (done_cnt < n_beats) else stop_run("beat_done after the end of the burst");
                if (done_cnt == fail_beat) begin
                    assert (beat_error && burst_error && burst_done)
                        else report_mismatch("beat_error,burst_error,burst_done",
                                             {beat_error, burst_error, burst_done}, 3'b111);
                end else begin
                    assert (!beat_error) else report_mismatch("beat_error", beat_error, 0);
                    assert (burst_done == (done_cnt == n_beats - 1))
                        else report_mismatch("burst_done", burst_done, done_cnt == n_beats - 1);
                    if (cur_write) begin
                        ref_mem[exp_addr[done_cnt][11:0]] = wdata[done_cnt];
                    end else begin
                        assert (rd_data == ref_mem[exp_addr[done_cnt][11:0]])
                            else report_mismatch("rd_data", rd_data,
                                                 ref_mem[exp_addr[done_cnt][11:0]]);
                    end
                end
                done_cnt++;
            end
        end
    end

    assert property (@(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
                     (hresp && !hready) |=> (htrans == IDLE))
        else report_mismatch("htrans", htrans, IDLE);
    assert property (@(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
                     cmd_error |-> (cmd_accept && htrans == IDLE))
        else report_mismatch("cmd_accept", cmd_accept, 1);

    initial begin
        seed        = $urandom(26);
        ahb_rstn_in = 1'b0;
        cmd_valid   = 1'b0;
        cmd_addr    = '0;
        cmd_burst   = SINGLE;
        cmd_size    = WORD;
        cmd_write   = 1'b0;
        wr_data     = '0;
        n_beats     = 0;
        fail_beat   = -1;
        cur_write   = 1'b0;
        cur_burst   = SINGLE;
        cur_size    = WORD;
        beat_idx    = 0;
        done_cnt    = 0;
        wr_idx      = 0;
        repeat (8) @(negedge ahb_clk_in);
        ahb_rstn_in = 1'b1;
        @(negedge ahb_clk_in);
        assert (htrans == IDLE) else report_mismatch("htrans", htrans, IDLE);
        assert ({cmd_accept, cmd_error, wr_take, beat_done, burst_done} == '0)
            else report_mismatch("client pulses", {cmd_accept, cmd_error, wr_take, beat_done,
                                                   burst_done}, 0);
        for (i = 0; i < 4; i++) run_cmd(32'h7C0 + 4 * i, SINGLE, WORD, 1'b1, -1, 20);
        for (i = 0; i < 4; i++) run_cmd(32'h7C0 + 4 * i, SINGLE, WORD, 1'b0, -1, 20);
        for (i = 0; i < 3; i++) begin
            sz    = hsize_t'($urandom % 3);
            start = (($urandom % 32'h600) >> sz) << sz;
            run_cmd(start, i == 0 ? INCR4 : (i == 1 ? INCR8 : INCR16), sz, 1'b1, -1, 100);
            run_cmd(start, i == 0 ? INCR4 : (i == 1 ? INCR8 : INCR16), sz, 1'b0, -1, 100);
        end
        for (i = 0; i < 3; i++) begin
            sz    = hsize_t'($urandom % 3);
            // never slot 0 of the wrap block
            start = 32'h600 + 32'h80 * i + ((1 + $urandom % ((4 << i) - 1)) << sz);
            run_cmd(start, i == 0 ? WRAP4 : (i == 1 ? WRAP8 : WRAP16), sz, 1'b1, -1, 100);
            run_cmd(start, i == 0 ? WRAP4 : (i == 1 ? WRAP8 : WRAP16), sz, 1'b0, -1, 100);
        end
        reject_cmd(32'h10, SINGLE, DWORD);
        reject_cmd(32'h3FE, INCR4, WORD);
        run_cmd(32'h7F8, INCR4, WORD, 1'b1, 2, 40);  // third beat hits the error address
        run_cmd(32'hC00, SINGLE, WORD, 1'b0, 0, `AHB_WAIT_TIMEOUT + 2);
        run_cmd(32'h40, SINGLE, WORD, 1'b1, -1, 20);
        run_cmd(32'h40, SINGLE, WORD, 1'b0, -1, 20);
        $display("TEST OK");
        $finish;
    end

endmodule

/* ahb_master_top.f */
+incdir+include
source/ahb_bus_pkg.sv
source/ahb_master_pkg.sv
source/ahb_cmd_check.sv
source/ahb_addr_gen.sv
source/ahb_master_fsm.sv
source/ahb_data_phase.sv
source/ahb_master_top.sv
test/ahb_slave_model.sv
test/tb_ahb_master.sv
